//--- tb.f
fetch_pkg.sv
thread_pc.sv
thread_select.sv
inst_mem.sv
if_stage.sv
fetch_top.sv
tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_front_end

sources:
  - fetch_pkg.sv
  - thread_pc.sv
  - thread_select.sv
  - inst_mem.sv
  - if_stage.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_fetch.sv

//--- tb_fetch.sv
// directed testbench for the two-thread fetch front end; compile with tb.f and run tb_fetch as top
`timescale 1ns/1ns

module tb_fetch;
	import fetch_pkg::*;

	localparam logic [addr_width-1:0] t1_reset_pc   = 64'h0000_0000_0000_0000;
	localparam logic [addr_width-1:0] t2_reset_pc   = 64'h0000_0000_0000_0400;
	localparam logic [addr_width-1:0] branch_target = 64'h0000_0000_0000_0204;	// upper word entry
	localparam int mem_lines  = 256;
	localparam int wait_limit = 20;	// cycles allowed for one delivery

	logic clock, reset, two_threads;
	logic rs_stall, rat_stall, rob1_stall, rob2_stall;
	logic thread1_hazard_stall, thread2_hazard_stall;
	logic branch1_taken, branch2_taken;
	logic [addr_width-1:0] target1, target2, wr_addr;
	logic wr_enable;
	logic [line_width-1:0] wr_data;
	logic fetch_valid, fetch_thread, inst1_valid, inst2_valid;
	logic [addr_width-1:0] fetch_pc;
	logic [inst_width-1:0] inst1, inst2;

	logic [line_width-1:0] mem_model [mem_lines];	// expected memory image
	logic [addr_width-1:0] exp_pc [2];				// next line expected per thread
	logic                  exp_upper [2];			// next line enters on upper word
	logic [63:0]           rng_state;
	int errors, checks;
	bit timed_out;

	fetch_top #(.thread1_reset_pc(t1_reset_pc), .thread2_reset_pc(t2_reset_pc),
		.mem_lines(mem_lines)) dut (
		.clock(clock), .reset(reset), .two_threads(two_threads),
		.rs_stall(rs_stall), .rat_stall(rat_stall), .rob1_stall(rob1_stall),
		.rob2_stall(rob2_stall), .thread1_hazard_stall(thread1_hazard_stall),
		.thread2_hazard_stall(thread2_hazard_stall),
		.branch1_taken(branch1_taken), .branch2_taken(branch2_taken),
		.target1(target1), .target2(target2),
		.wr_enable(wr_enable), .wr_addr(wr_addr), .wr_data(wr_data),
		.fetch_valid(fetch_valid), .fetch_thread(fetch_thread), .fetch_pc(fetch_pc),
		.inst1(inst1), .inst2(inst2), .inst1_valid(inst1_valid), .inst2_valid(inst2_valid)
	);

	always #2 clock = ~clock;	// 4 ns period

	////////////////////
	// helpers
	////////////////////

	function automatic logic [63:0] next_random(input logic [63:0] state);
		logic [63:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 7);
		s = s ^ (s << 17);
		return s;
	endfunction

	// a line on the outputs means a load left one cycle earlier
	function automatic bus_command_e seen_command(input logic any_valid);
		return any_valid ? cmd_load : cmd_none;
	endfunction

	task automatic drive_point;
		@(posedge clock);
		#1;	// inputs move just after the edge
	endtask

	task automatic check_line(input string name, input logic [addr_width-1:0] want_pc,
			input logic [inst_width-1:0] want_i1, input logic [inst_width-1:0] want_i2,
			input logic want_v1, input logic want_v2);
		checks++;
		if (fetch_pc !== want_pc) begin
			errors++;
			$display("Error %s: fetch_pc expected %h actual %h", name, want_pc, fetch_pc);
		end
		if (inst1 !== want_i1 || inst1_valid !== want_v1) begin
			errors++;
			$display("Error %s: inst1/valid expected %h/%b actual %h/%b", name,
				want_i1, want_v1, inst1, inst1_valid);
		end
		if (inst2 !== want_i2 || inst2_valid !== want_v2) begin
			errors++;
			$display("Error %s: inst2/valid expected %h/%b actual %h/%b", name,
				want_i2, want_v2, inst2, inst2_valid);
		end
	endtask

	// thread numbers print from 1
	task automatic check_thread(input string name, input logic want, input logic got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error %s: thread expected %0d actual %0d", name, want + 1, got + 1);
		end
	endtask

	task automatic check_command(input string name, input bus_command_e want,
			input bus_command_e got);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error %s: command expected %s actual %s", name, want.name(), got.name());
		end
	endtask

	// one cycle of the output side; a delivered line is checked and moves the model on
	task automatic sample_cycle(input string name, output logic got, output logic thr);
		logic [line_width-1:0] line;
		int idx;
		@(negedge clock);
		got = fetch_valid;
		thr = fetch_thread;
		if (fetch_valid) begin
			idx  = int'((exp_pc[thr] / line_bytes) % mem_lines);
			line = mem_model[idx];
			check_line(name, exp_pc[thr],
				exp_upper[thr] ? {inst_width{1'b0}} : line[inst_width-1:0],
				line[line_width-1:inst_width], ~exp_upper[thr], 1'b1);
			exp_pc[thr]    = exp_pc[thr] + line_bytes;
			exp_upper[thr] = 1'b0;
		end
	endtask

	task automatic next_delivery(input string name, output logic thr);
		logic got;
		int cycles;
		got = 1'b0;
		cycles = 0;
		thr = 1'b0;
		while (!got && cycles < wait_limit && !timed_out) begin
			sample_cycle(name, got, thr);
			cycles++;
		end
		if (!got && !timed_out) begin
			errors++;
			timed_out = 1'b1;
			$display("%s: no line delivered within %0d cycles", name, wait_limit);
		end
	endtask

	// waits a few deliveries for one line of the wanted thread
	task automatic deliver_thread(input string name, input logic want, output logic found);
		logic thr;
		int n;
		found = 1'b0;
		n = 0;
		while (!found && n < 4 && !timed_out) begin
			next_delivery(name, thr);
			found = !timed_out && (thr == want);
			n++;
		end
		if (!found && !timed_out) begin
			errors++;
			$display("%s: thread %0d got no line in four deliveries", name, want + 1);
		end
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_single_stream;
		logic thr;
		drive_point();
		two_threads = 1'b0;
		rs_stall    = 1'b0;	// fetch starts here
		repeat (6) begin
			next_delivery("single_stream", thr);
			if (timed_out) return;
			check_thread("single_stream", 1'b0, thr);
		end
	endtask

	task automatic test_interleave;
		logic thr, want;
		drive_point();
		two_threads = 1'b1;
		want = 1'b0;	// last single thread request is still in flight
		repeat (8) begin
			next_delivery("interleave", thr);
			if (timed_out) return;
			check_thread("interleave", want, thr);
			want = ~want;	// free threads take turns
		end
	endtask

	task automatic test_thread_stall;
		logic thr, got, found;
		drive_point();
		rob1_stall = 1'b1;
		sample_cycle("thread_stall", got, thr);	// in-flight line may be either thread
		repeat (6) begin
			next_delivery("thread_stall", thr);
			if (timed_out) return;
			check_thread("thread_stall", 1'b1, thr);
		end
		drive_point();
		rob1_stall = 1'b0;
		deliver_thread("thread_stall", 1'b0, found);	// resumes at model pc
	endtask

	task automatic test_shared_stall;
		logic thr, got, found;
		drive_point();
		rs_stall = 1'b1;
		sample_cycle("shared_stall", got, thr);	// at most this one line
		repeat (6) begin
			sample_cycle("shared_stall", got, thr);
			check_command("shared_stall", cmd_none,
				seen_command(fetch_valid | inst1_valid | inst2_valid));
		end
		drive_point();
		rs_stall = 1'b0;
		deliver_thread("shared_stall", 1'b0, found);
		deliver_thread("shared_stall", 1'b1, found);
	endtask

	task automatic test_redirect;
		logic thr, got, found;
		drive_point();
		branch1_taken = 1'b1;
		target1       = branch_target;
		exp_pc[0]     = branch_target - (branch_target % line_bytes);	// line aligned
		exp_upper[0]  = branch_target[2];
		sample_cycle("redirect", got, thr);	// old thread 1 line must not show here
		drive_point();
		branch1_taken = 1'b0;
		deliver_thread("redirect", 1'b0, found);	// partial target line
		deliver_thread("redirect", 1'b0, found);	// full line after it
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		two_threads = 1'b0;
		rs_stall = 1'b1;	// holds fetch while memory loads
		rat_stall = 1'b0;
		rob1_stall = 1'b0;
		rob2_stall = 1'b0;
		thread1_hazard_stall = 1'b0;
		thread2_hazard_stall = 1'b0;
		branch1_taken = 1'b0;
		branch2_taken = 1'b0;
		target1 = '0;
		target2 = '0;
		wr_enable = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		rng_state = 64'd70;
		for (int i = 0; i < mem_lines; i++) begin
			rng_state    = next_random(rng_state);
			mem_model[i] = rng_state;
		end
		exp_pc[0] = t1_reset_pc;
		exp_pc[1] = t2_reset_pc;
		exp_upper[0] = 1'b0;
		exp_upper[1] = 1'b0;

		// preload runs through reset, which drops after eight edges
		for (int i = 0; i < mem_lines; i++) begin
			drive_point();
			if (i == 7) reset = 1'b0;
			wr_enable = 1'b1;
			wr_addr   = addr_width'(i * line_bytes);
			wr_data   = mem_model[i];
			@(negedge clock);
			check_command("reset_preload", cmd_none,
				seen_command(fetch_valid | inst1_valid | inst2_valid));
		end
		drive_point();
		wr_enable = 1'b0;

		test_single_stream();
		test_interleave();
		test_thread_stall();
		test_shared_stall();
		test_redirect();

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- fetch_top.sv
// top level of the two-thread fetch front end; connects both pcs, the selector, fetch control and memory
`timescale 1ns/1ns

module fetch_top #(
	parameter logic [fetch_pkg::addr_width-1:0] thread1_reset_pc = 64'h0000_0000_0000_0000,
	parameter logic [fetch_pkg::addr_width-1:0] thread2_reset_pc = 64'h0000_0000_0000_0400,
	parameter int                               mem_lines        = 256
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             two_threads,
	input  logic                             rs_stall,
	input  logic                             rat_stall,
	input  logic                             rob1_stall,
	input  logic                             rob2_stall,
	input  logic                             thread1_hazard_stall,
	input  logic                             thread2_hazard_stall,
	input  logic                             branch1_taken,
	input  logic                             branch2_taken,
	input  logic [fetch_pkg::addr_width-1:0] target1,
	input  logic [fetch_pkg::addr_width-1:0] target2,
	input  logic                             wr_enable,		// preload only while fetch is stalled
	input  logic [fetch_pkg::addr_width-1:0] wr_addr,
	input  logic [fetch_pkg::line_width-1:0] wr_data,
	output logic                             fetch_valid,
	output logic                             fetch_thread,
	output logic [fetch_pkg::addr_width-1:0] fetch_pc,
	output logic [fetch_pkg::inst_width-1:0] inst1,
	output logic [fetch_pkg::inst_width-1:0] inst2,
	output logic                             inst1_valid,
	output logic                             inst2_valid
);
	import fetch_pkg::*;

	logic [addr_width-1:0] pc1, pc2;
	logic                  upper1, upper2;
	logic                  advance1, advance2;
	logic                  sel_enable;	// selector grant
	logic                  sel_thread;	// selector choice
	logic                  issued;
	bus_command_e          mem_command;
	logic [addr_width-1:0] mem_addr;
	logic                  mem_thread;
	logic                  resp_valid;
	logic                  resp_thread;
	logic [line_width-1:0] resp_data;

	thread_pc #(.reset_pc(thread1_reset_pc)) u_pc1 (
		.clock(clock), .reset(reset), .advance(advance1), .redirect(branch1_taken),
		.target(target1), .pc(pc1), .upper_entry(upper1)
	);

	thread_pc #(.reset_pc(thread2_reset_pc)) u_pc2 (
		.clock(clock), .reset(reset), .advance(advance2), .redirect(branch2_taken),
		.target(target2), .pc(pc2), .upper_entry(upper2)
	);

	thread_select u_select (
		.clock(clock), .reset(reset), .two_threads(two_threads),
		.rs_stall(rs_stall), .rat_stall(rat_stall),
		.rob1_stall(rob1_stall), .rob2_stall(rob2_stall),
		.thread1_hazard_stall(thread1_hazard_stall),
		.thread2_hazard_stall(thread2_hazard_stall),
		.issued(issued), .fetch_enable(sel_enable), .fetch_thread(sel_thread)
	);

	if_stage u_if (
		.clock(clock), .reset(reset), .fetch_enable(sel_enable), .fetch_thread(sel_thread),
		.pc1(pc1), .pc2(pc2), .upper1(upper1), .upper2(upper2),
		.branch1_taken(branch1_taken), .branch2_taken(branch2_taken),
		.resp_valid(resp_valid), .resp_thread(resp_thread), .resp_data(resp_data),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_thread(mem_thread),
		.advance1(advance1), .advance2(advance2), .issued(issued),
		.fetch_valid(fetch_valid), .fetch_thread_out(fetch_thread), .fetch_pc(fetch_pc),
		.inst1(inst1), .inst2(inst2), .inst1_valid(inst1_valid), .inst2_valid(inst2_valid)
	);

	inst_mem #(.mem_lines(mem_lines)) u_mem (
		.clock(clock), .reset(reset), .mem_command(mem_command), .mem_addr(mem_addr),
		.mem_thread(mem_thread), .wr_enable(wr_enable), .wr_addr(wr_addr), .wr_data(wr_data),
		.resp_valid(resp_valid), .resp_thread(resp_thread), .resp_data(resp_data)
	);

endmodule

//--- if_stage.sv
// fetch control; issues one line load per cycle and splits the returned line into two tagged instructions
`timescale 1ns/1ns

module if_stage (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             fetch_enable,	// selector found a free thread
	input  logic                             fetch_thread,	// selected thread
	input  logic [fetch_pkg::addr_width-1:0] pc1,			// thread 1 line address
	input  logic [fetch_pkg::addr_width-1:0] pc2,			// thread 2 line address
	input  logic                             upper1,			// thread 1 enters on upper word
	input  logic                             upper2,			// thread 2 enters on upper word
	input  logic                             branch1_taken,	// thread 1 redirect this cycle
	input  logic                             branch2_taken,	// thread 2 redirect this cycle
	input  logic                             resp_valid,		// memory answered
	input  logic                             resp_thread,	// owner of the answer
	input  logic [fetch_pkg::line_width-1:0] resp_data,		// returned line
	output fetch_pkg::bus_command_e          mem_command,
	output logic [fetch_pkg::addr_width-1:0] mem_addr,
	output logic                             mem_thread,
	output logic                             advance1,		// step thread 1 pc
	output logic                             advance2,		// step thread 2 pc
	output logic                             issued,			// request left this cycle
	output logic                             fetch_valid,	// line delivered this cycle
	output logic                             fetch_thread_out,
	output logic [fetch_pkg::addr_width-1:0] fetch_pc,
	output logic [fetch_pkg::inst_width-1:0] inst1,			// low word
	output logic [fetch_pkg::inst_width-1:0] inst2,			// high word
	output logic                             inst1_valid,
	output logic                             inst2_valid
);
	import fetch_pkg::*;

	logic                  running;		// low in the cycle after reset
	logic                  branch_sel;	// selected thread is being redirected
	logic                  issue;		// a load goes out this cycle
	logic [addr_width-1:0] sel_pc;		// line address of selected thread
	logic                  sel_upper;	// entry flag of selected thread

	logic [addr_width-1:0] pending_pc;		// address of the line in flight
	logic                  pending_upper;	// line in flight starts on its upper word

	logic                  squash;		// delivered line belongs to a redirected thread
	logic                  low_ok;		// low word may be used

	////////////////////
	// request side
	////////////////////

	// first cycle after reset stays idle
	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
		end else begin
			running <= 1'b1;
		end
	end

	assign sel_pc     = fetch_thread ? pc2 : pc1;
	assign sel_upper  = fetch_thread ? upper2 : upper1;
	assign branch_sel = fetch_thread ? branch2_taken : branch1_taken;

	// a thread redirected this cycle still holds its old pc
	// so its request waits for the target to load
	assign issue = running & fetch_enable & ~branch_sel;

	always_comb begin
		mem_command = cmd_none;
		if (issue) begin
			mem_command = cmd_load;
		end
	end

	assign mem_addr   = sel_pc;
	assign mem_thread = fetch_thread;
	assign issued     = issue;

	assign advance1 = issue & ~fetch_thread;	// pc steps at the end of the issue cycle
	assign advance2 = issue & fetch_thread;

	// capture what goes with the line in flight
	always_ff @(posedge clock) begin
		if (issue) begin
			pending_pc    <= sel_pc;
			pending_upper <= sel_upper;
		end
	end

	////////////////////
	// response side
	////////////////////

	// a redirect during delivery kills the old path line
	assign squash = resp_thread ? branch2_taken : branch1_taken;

	assign fetch_valid      = resp_valid & ~squash;
	assign fetch_thread_out = resp_thread;
	assign fetch_pc         = pending_pc;

	assign low_ok = ~pending_upper;	// entry on upper word skips the low instruction

	assign inst1_valid = fetch_valid & low_ok;
	assign inst2_valid = fetch_valid;

	// unused slots read as zero
	always_comb begin
		inst1 = '0;
		inst2 = '0;
		if (inst1_valid) begin
			inst1 = resp_data[inst_width-1:0];
		end
		if (inst2_valid) begin
			inst2 = resp_data[line_width-1:inst_width];
		end
	end

endmodule

//--- inst_mem.sv
// line wide on-chip instruction memory with a preload write port and one-cycle read response
`timescale 1ns/1ns

module inst_mem #(
	parameter int mem_lines = 256	// number of lines held
) (
	input  logic                             clock,
	input  logic                             reset,
	input  fetch_pkg::bus_command_e          mem_command,	// load request from fetch
	input  logic [fetch_pkg::addr_width-1:0] mem_addr,		// byte address of requested line
	input  logic                             mem_thread,	// thread that owns the request
	input  logic                             wr_enable,		// preload strobe
	input  logic [fetch_pkg::addr_width-1:0] wr_addr,		// preload byte address
	input  logic [fetch_pkg::line_width-1:0] wr_data,		// preload line
	output logic                             resp_valid,	// load answered this cycle
	output logic                             resp_thread,	// owner of the answered load
	output logic [fetch_pkg::line_width-1:0] resp_data		// answered line
);
	import fetch_pkg::*;

	localparam int idx_bits = (mem_lines > 1) ? $clog2(mem_lines) : 1;

	logic [line_width-1:0] lines [mem_lines];	// storage

	logic [addr_width-1:0] rd_line_full;	// read line number wrapped to the array
	logic [addr_width-1:0] wr_line_full;	// write line number wrapped to the array
	logic [idx_bits-1:0]   rd_index;
	logic [idx_bits-1:0]   wr_index;

	// line number is address over line size modulo depth
	assign rd_line_full = (mem_addr >> line_offset_bits) % addr_width'(mem_lines);
	assign wr_line_full = (wr_addr >> line_offset_bits) % addr_width'(mem_lines);
	assign rd_index     = rd_line_full[idx_bits-1:0];
	assign wr_index     = wr_line_full[idx_bits-1:0];

	////////////////////
	// storage
	////////////////////

	always_ff @(posedge clock) begin
		if (wr_enable) begin
			lines[wr_index] <= wr_data;	// preload lands at this edge
		end
	end

	////////////////////
	// read response
	////////////////////

	// data and owner trail the request by one cycle
	always_ff @(posedge clock) begin
		resp_data   <= lines[rd_index];
		resp_thread <= mem_thread;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= (mem_command == cmd_load);	// answer one cycle after the load
		end
	end

endmodule

//--- thread_select.sv
// picks which thread may fetch this cycle from the stalls, the thread mode and round-robin history
`timescale 1ns/1ns

module thread_select (
	input  logic clock,
	input  logic reset,
	input  logic two_threads,			// high when both threads run
	input  logic rs_stall,				// reservation station full
	input  logic rat_stall,				// free list empty
	input  logic rob1_stall,				// rob of thread 1 full
	input  logic rob2_stall,				// rob of thread 2 full
	input  logic thread1_hazard_stall,	// memory port taken by thread 1 data access
	input  logic thread2_hazard_stall,	// memory port taken by thread 2 data access
	input  logic issued,					// a request went out this cycle
	output logic fetch_enable,			// some thread may fetch
	output logic fetch_thread			// 0 selects thread 1 and 1 selects thread 2
);

	logic t1_free;		// thread 1 has no stall
	logic t2_free;		// thread 2 has no stall
	logic last_thread;	// thread that issued most recently
	logic preferred;		// thread that did not fetch last

	// shared stalls block both threads
	assign t1_free = ~(rs_stall | rat_stall | rob1_stall | thread1_hazard_stall);
	assign t2_free = ~(rs_stall | rat_stall | rob2_stall | thread2_hazard_stall);

	assign preferred = ~last_thread;

	always_comb begin
		fetch_enable = 1'b0;
		fetch_thread = 1'b0;
		if (!two_threads) begin
			fetch_enable = t1_free;	// single thread mode runs thread 1 only
		end else if (preferred ? t2_free : t1_free) begin
			fetch_enable = 1'b1;
			fetch_thread = preferred;
		end else if (preferred ? t1_free : t2_free) begin
			fetch_enable = 1'b1;		// preferred one stalled so fall back
			fetch_thread = ~preferred;
		end
	end

	// history moves only when a request really left
	always_ff @(posedge clock) begin
		if (reset) begin
			last_thread <= 1'b1;	// thread 1 goes first
		end else if (issued) begin
			last_thread <= fetch_thread;
		end
	end

endmodule

//--- thread_pc.sv
// per-thread program counter; steps one line per advance and loads an aligned branch target
`timescale 1ns/1ns

module thread_pc #(
	parameter logic [fetch_pkg::addr_width-1:0] reset_pc = '0	// first fetch address
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           advance,		// line of this thread was requested
	input  logic                           redirect,		// taken branch of this thread
	input  logic [fetch_pkg::addr_width-1:0] target,		// branch target byte address
	output logic [fetch_pkg::addr_width-1:0] pc,			// line aligned fetch address
	output logic                           upper_entry	// next line entered on its upper word
);
	import fetch_pkg::*;

	logic [addr_width-1:0] reset_line;	// reset pc aligned down to a line
	logic [addr_width-1:0] target_line;	// target aligned down to a line
	logic [addr_width-1:0] next_line;	// sequential successor

	assign reset_line  = reset_pc & line_mask;
	assign target_line = target & line_mask;
	assign next_line   = pc + addr_width'(line_bytes);

	// redirect wins over advance in the same cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			pc          <= reset_line;
			upper_entry <= 1'b0;
		end else if (redirect) begin
			pc          <= target_line;
			upper_entry <= target[word_sel_bit];	// low word of target line is skipped
		end else if (advance) begin
			pc          <= next_line;
			upper_entry <= 1'b0;	// only the first line after a redirect is partial
		end
	end

endmodule

//--- fetch_pkg.sv
// shared widths, memory command encoding and line geometry for the fetch front end RTL
package fetch_pkg;

	////////////////////
	// datapath widths
	////////////////////

	localparam int addr_width = 64;	// pc and memory address width
	localparam int inst_width = 32;	// one instruction
	localparam int line_width = 64;	// one fetched line holds two instructions

	////////////////////
	// line geometry
	////////////////////

	// address step from one line to the next
	localparam int line_bytes = 8;

	// low address bits that select a byte inside a line
	localparam int line_offset_bits = 3;

	// address bit that picks the upper instruction of a line
	localparam int word_sel_bit = 2;

	// mask that clears the in-line offset of an address
	localparam logic [addr_width-1:0] line_mask = ~addr_width'(line_bytes - 1);

	////////////////////
	// memory commands
	////////////////////

	// request on the instruction memory port
	typedef enum logic [1:0] {
		cmd_none = 2'd0,	// idle cycle
		cmd_load = 2'd1	// read one line
	} bus_command_e;

endpackage
